/* rtl/dkjr_defs.svh */
`ifndef DKJR_DEFS_SVH
`define DKJR_DEFS_SVH

// ------------------------------------------------------------
// Shared ROM round
// ------------------------------------------------------------

// Slots in one round of the ROM scheduler
`define DKJR_SLOTS 16

// ------------------------------------------------------------
// Graphics bank nibbles
// ------------------------------------------------------------

// Background tile ROMs
`define DKJR_VID1_BANK 4'h6
`define DKJR_VID2_BANK 4'h7

// Sprite ROMs, one nibble per plane
`define DKJR_OBJ1_BANK 4'hA
`define DKJR_OBJ2_BANK 4'hB
`define DKJR_OBJ3_BANK 4'hC
`define DKJR_OBJ4_BANK 4'hD

// Wave samples sit above the whole program area
`define DKJR_WAV_BANK 3'b001

// ------------------------------------------------------------
// Sound mixer
// ------------------------------------------------------------

// Midscale of one unsigned biased sample
`define DKJR_MIX_BIAS 9'h080

// Sum at or above this clips to full scale
`define DKJR_MIX_POS_LIM 9'h17F

// Sum at or below this clips to zero
`define DKJR_MIX_NEG_LIM 9'h080

`endif

/* rtl/dkjr_pkg.sv */
package dkjr_pkg;

	// ------------------------------------------------------------
	// Address types
	// ------------------------------------------------------------

	// Full address of the shared external ROM
	typedef logic [18:0] rom_addr_t;

	// Program CPU address bus
	typedef logic [15:0] cpu_addr_t;

	// Offset inside one 4 KB graphics bank
	typedef logic [11:0] tile_addr_t;

	// Wave sample address from the sound player
	typedef logic [15:0] wav_addr_t;

	// 2 KB bank index, top 8 bits of a ROM address
	typedef logic [7:0] bank_t;

	// ------------------------------------------------------------
	// Data and control types
	// ------------------------------------------------------------

	// One byte back from the ROM
	typedef logic [7:0] rom_byte_t;

	// Slot number within the round
	typedef logic [3:0] phase_t;

	// Unsigned sound sample, midscale at 80 hex
	typedef logic [7:0] snd_t;

	// Sum of two samples with its carry
	typedef logic [8:0] mix_t;

endpackage

/* rtl/rom_phase_gen.sv */
`timescale 1ns/1ps

`include "dkjr_defs.svh"

module rom_phase_gen (
	input  logic              W_CLK_12288M,
	input  logic              I_RESETn,
	input  logic              slot_sync,
	output dkjr_pkg::phase_t  phase
);

	// ------------------------------------------------------------
	// Sync capture
	// ------------------------------------------------------------

	// Two stage shift of the video timing level
	logic [1:0] sync_q;

	// High for one cycle after a registered rising edge
	logic sync_rise;

	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			sync_q <= 2'b00;
		end else begin
			sync_q[0] <= slot_sync;
			sync_q[1] <= sync_q[0];
		end
	end

	// New level seen in stage 0, old level still in stage 1
	assign sync_rise = sync_q[0] & ~sync_q[1];

	// ------------------------------------------------------------
	// Slot counter
	// ------------------------------------------------------------

	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			phase <= '0;
		end else if (sync_rise) begin
			// Restart the round, even in mid round
			phase <= '0;
		end else if (phase == dkjr_pkg::phase_t'(`DKJR_SLOTS - 1)) begin
			// Last slot wraps back to the first
			phase <= '0;
		end else begin
			phase <= phase + dkjr_pkg::phase_t'(1);
		end
	end

endmodule

/* rtl/prog_bank_remap.sv */
`timescale 1ns/1ps

module prog_bank_remap (
	input  dkjr_pkg::cpu_addr_t  cpu_addr,
	output dkjr_pkg::rom_addr_t  prog_addr
);

	// ------------------------------------------------------------
	// Address split
	// ------------------------------------------------------------

	// CPU address widened to the ROM bus
	dkjr_pkg::rom_addr_t cpu_wide;

	// Bank the CPU asks for
	dkjr_pkg::bank_t cpu_bank;

	// Bank where that data lives in the ROM file
	dkjr_pkg::bank_t file_bank;

	assign cpu_wide = {3'b000, cpu_addr};
	assign cpu_bank = cpu_wide[18:11];

	// ------------------------------------------------------------
	// Bank swap table
	// ------------------------------------------------------------

	always_comb begin
		case (cpu_bank)
			// 1000 hex area is stored at 3000 hex
			8'h02: file_bank = 8'h06;
			8'h03: file_bank = 8'h0B;
			8'h05: file_bank = 8'h09;
			// 3000 hex area is stored at 1000 hex
			8'h06: file_bank = 8'h02;
			8'h07: file_bank = 8'h03;
			8'h09: file_bank = 8'h05;
			8'h0B: file_bank = 8'h07;
			// Everything else is in place
			default: file_bank = cpu_bank;
		endcase
	end

	// Offset inside the 2 KB bank is kept
	assign prog_addr = {file_bank, cpu_wide[10:0]};

endmodule

/* rtl/rom_slot_sequencer.sv */
`timescale 1ns/1ps

`include "dkjr_defs.svh"

module rom_slot_sequencer (
	input  logic                 W_CLK_12288M,
	input  logic                 I_RESETn,
	input  dkjr_pkg::phase_t     phase,
	input  dkjr_pkg::rom_addr_t  prog_addr,
	input  dkjr_pkg::tile_addr_t vid_addr,
	input  dkjr_pkg::tile_addr_t obj_addr,
	input  dkjr_pkg::wav_addr_t  wav_addr,
	input  dkjr_pkg::rom_byte_t  rom_data,
	output dkjr_pkg::rom_addr_t  rom_addr,
	output dkjr_pkg::rom_byte_t  prog_data,
	output dkjr_pkg::rom_byte_t  wav_data,
	output dkjr_pkg::rom_byte_t  vid1_data,
	output dkjr_pkg::rom_byte_t  vid2_data,
	output dkjr_pkg::rom_byte_t  obj1_data,
	output dkjr_pkg::rom_byte_t  obj2_data,
	output dkjr_pkg::rom_byte_t  obj3_data,
	output dkjr_pkg::rom_byte_t  obj4_data
);

	// ------------------------------------------------------------
	// Client addresses on the shared bus
	// ------------------------------------------------------------

	// Wave player in its own high area
	dkjr_pkg::rom_addr_t wav_rom;

	// Background tile planes
	dkjr_pkg::rom_addr_t vid1_rom;
	dkjr_pkg::rom_addr_t vid2_rom;

	// Sprite planes
	dkjr_pkg::rom_addr_t obj1_rom;
	dkjr_pkg::rom_addr_t obj2_rom;
	dkjr_pkg::rom_addr_t obj3_rom;
	dkjr_pkg::rom_addr_t obj4_rom;

	assign wav_rom  = {`DKJR_WAV_BANK, wav_addr};
	assign vid1_rom = {3'b000, `DKJR_VID1_BANK, vid_addr};
	assign vid2_rom = {3'b000, `DKJR_VID2_BANK, vid_addr};
	assign obj1_rom = {3'b000, `DKJR_OBJ1_BANK, obj_addr};
	assign obj2_rom = {3'b000, `DKJR_OBJ2_BANK, obj_addr};
	assign obj3_rom = {3'b000, `DKJR_OBJ3_BANK, obj_addr};
	assign obj4_rom = {3'b000, `DKJR_OBJ4_BANK, obj_addr};

	// ------------------------------------------------------------
	// Slot schedule
	// ------------------------------------------------------------

	// ROM answers the held address in the same cycle
	// so each slot takes the byte of the address set one slot before
	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			rom_addr  <= '0;
			prog_data <= '0;
			wav_data  <= '0;
			vid1_data <= '0;
			vid2_data <= '0;
			obj1_data <= '0;
			obj2_data <= '0;
			obj3_data <= '0;
			obj4_data <= '0;
		end else begin
			case (phase)
				4'd0: begin
					// Program byte from slot 15, then wave fetch
					prog_data <= rom_data;
					rom_addr  <= wav_rom;
				end
				4'd1: begin
					wav_data <= rom_data;
				end
				4'd2: begin
					rom_addr <= prog_addr;
				end
				4'd3: begin
					prog_data <= rom_data;
					rom_addr  <= vid1_rom;
				end
				4'd4: begin
					vid1_data <= rom_data;
					rom_addr  <= vid2_rom;
				end
				4'd5: begin
					vid2_data <= rom_data;
					rom_addr  <= prog_addr;
				end
				4'd6: begin
					prog_data <= rom_data;
				end
				4'd8: begin
					rom_addr <= prog_addr;
				end
				4'd9: begin
					// Program byte, then first sprite plane
					prog_data <= rom_data;
					rom_addr  <= obj1_rom;
				end
				4'd10: begin
					obj1_data <= rom_data;
					rom_addr  <= obj2_rom;
				end
				4'd11: begin
					obj2_data <= rom_data;
					rom_addr  <= prog_addr;
				end
				4'd12: begin
					prog_data <= rom_data;
					rom_addr  <= obj3_rom;
				end
				4'd13: begin
					obj3_data <= rom_data;
					rom_addr  <= obj4_rom;
				end
				4'd14: begin
					obj4_data <= rom_data;
				end
				4'd15: begin
					// Program fetch read back in slot 0
					rom_addr <= prog_addr;
				end
				// Slot 7 is idle
				default: ;
			endcase
		end
	end

endmodule

/* rtl/snd_mix_limit.sv */
`timescale 1ns/1ps

`include "dkjr_defs.svh"

module snd_mix_limit (
	input  logic                W_CLK_12288M,
	input  logic                I_RESETn,
	input  dkjr_pkg::rom_byte_t wav_data,
	input  dkjr_pkg::snd_t      dig_snd,
	output dkjr_pkg::snd_t      snd_out
);

	// ------------------------------------------------------------
	// Mix
	// ------------------------------------------------------------

	// Two biased samples carry twice the bias
	dkjr_pkg::mix_t mix_sum;

	// Sum with one bias removed
	dkjr_pkg::mix_t mix_unbias;

	assign mix_sum    = {1'b0, wav_data} + {1'b0, dig_snd};
	assign mix_unbias = mix_sum - `DKJR_MIX_BIAS;

	// ------------------------------------------------------------
	// Limiter
	// ------------------------------------------------------------

	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			snd_out <= '0;
		end else if (mix_sum >= `DKJR_MIX_POS_LIM) begin
			// Clip at full scale
			snd_out <= 8'hFF;
		end else if (mix_sum <= `DKJR_MIX_NEG_LIM) begin
			// Clip at zero
			snd_out <= 8'h00;
		end else begin
			snd_out <= mix_unbias[7:0];
		end
	end

endmodule

/* rtl/dkjr_rom_share.sv */
`timescale 1ns/1ps

module dkjr_rom_share (
	input  logic                 W_CLK_12288M,
	input  logic                 I_RESETn,

	// Video timing strobe
	input  logic                 slot_sync,

	// Client addresses
	input  dkjr_pkg::cpu_addr_t  cpu_addr,
	input  dkjr_pkg::tile_addr_t vid_addr,
	input  dkjr_pkg::tile_addr_t obj_addr,
	input  dkjr_pkg::wav_addr_t  wav_addr,

	// Digital sound sample
	input  dkjr_pkg::snd_t       dig_snd,

	// External ROM
	input  dkjr_pkg::rom_byte_t  rom_data,
	output dkjr_pkg::rom_addr_t  rom_addr,

	// Client bytes
	output dkjr_pkg::rom_byte_t  prog_data,
	output dkjr_pkg::rom_byte_t  vid1_data,
	output dkjr_pkg::rom_byte_t  vid2_data,
	output dkjr_pkg::rom_byte_t  obj1_data,
	output dkjr_pkg::rom_byte_t  obj2_data,
	output dkjr_pkg::rom_byte_t  obj3_data,
	output dkjr_pkg::rom_byte_t  obj4_data,
	output dkjr_pkg::rom_byte_t  wav_data,

	// Mixed sound
	output dkjr_pkg::snd_t       snd_out
);

	// Current slot
	dkjr_pkg::phase_t phase;

	// Program address in ROM file order
	dkjr_pkg::rom_addr_t prog_addr;

	// ------------------------------------------------------------
	// Slot timing and program remap, side by side
	// ------------------------------------------------------------

	rom_phase_gen i_rom_phase_gen (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.slot_sync    (slot_sync),
		.phase        (phase)
	);

	prog_bank_remap i_prog_bank_remap (
		.cpu_addr  (cpu_addr),
		.prog_addr (prog_addr)
	);

	// ------------------------------------------------------------
	// Bus owner per slot
	// ------------------------------------------------------------

	rom_slot_sequencer i_rom_slot_sequencer (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.phase        (phase),
		.prog_addr    (prog_addr),
		.vid_addr     (vid_addr),
		.obj_addr     (obj_addr),
		.wav_addr     (wav_addr),
		.rom_data     (rom_data),
		.rom_addr     (rom_addr),
		.prog_data    (prog_data),
		.wav_data     (wav_data),
		.vid1_data    (vid1_data),
		.vid2_data    (vid2_data),
		.obj1_data    (obj1_data),
		.obj2_data    (obj2_data),
		.obj3_data    (obj3_data),
		.obj4_data    (obj4_data)
	);

	// ------------------------------------------------------------
	// Wave plus digital sound
	// ------------------------------------------------------------

	snd_mix_limit i_snd_mix_limit (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.wav_data     (wav_data),
		.dig_snd      (dig_snd),
		.snd_out      (snd_out)
	);

endmodule

/* verif/tb_dkjr_rom_share.sv */
`timescale 1ns/1ps

`include "dkjr_defs.svh"

module tb_dkjr_rom_share;

	// ------------------------------------------------------------
	// Run length and timing
	// ------------------------------------------------------------

	localparam int clk_half       = 10;
	localparam int sched_rounds   = 40;
	localparam int mix_rounds     = 24;
	localparam int resync_rounds  = 40;
	localparam int resync_max_len = 20;

	// All rounds at their longest, plus reset and drain
	localparam int timeout_cycles = (sched_rounds + mix_rounds) * `DKJR_SLOTS
		+ resync_rounds * resync_max_len + 64;

	// Program banks that the board swaps
	localparam logic [4:0] remap_banks [7] = '{5'h02, 5'h03, 5'h05, 5'h06, 5'h07, 5'h09, 5'h0B};

	// Mixer sums on and around both limits
	localparam logic [8:0] mix_edges [8] = '{9'h000, 9'h07F, 9'h080, 9'h081,
		9'h17E, 9'h17F, 9'h180, 9'h1FE};

	// ------------------------------------------------------------
	// DUT signals
	// ------------------------------------------------------------

	logic                 W_CLK_12288M;
	logic                 I_RESETn;
	logic                 slot_sync;
	dkjr_pkg::cpu_addr_t  cpu_addr;
	dkjr_pkg::tile_addr_t vid_addr;
	dkjr_pkg::tile_addr_t obj_addr;
	dkjr_pkg::wav_addr_t  wav_addr;
	dkjr_pkg::snd_t       dig_snd;
	dkjr_pkg::rom_byte_t  rom_data;
	dkjr_pkg::rom_addr_t  rom_addr;
	dkjr_pkg::rom_byte_t  prog_data;
	dkjr_pkg::rom_byte_t  vid1_data;
	dkjr_pkg::rom_byte_t  vid2_data;
	dkjr_pkg::rom_byte_t  obj1_data;
	dkjr_pkg::rom_byte_t  obj2_data;
	dkjr_pkg::rom_byte_t  obj3_data;
	dkjr_pkg::rom_byte_t  obj4_data;
	dkjr_pkg::rom_byte_t  wav_data;
	dkjr_pkg::snd_t       snd_out;

	// Reference model state
	logic [1:0]          m_sync;
	dkjr_pkg::phase_t    m_phase;
	dkjr_pkg::rom_addr_t m_addr;
	dkjr_pkg::rom_byte_t m_prog;
	dkjr_pkg::rom_byte_t m_wav;
	dkjr_pkg::rom_byte_t m_vid1;
	dkjr_pkg::rom_byte_t m_vid2;
	dkjr_pkg::rom_byte_t m_obj1;
	dkjr_pkg::rom_byte_t m_obj2;
	dkjr_pkg::rom_byte_t m_obj3;
	dkjr_pkg::rom_byte_t m_obj4;
	dkjr_pkg::snd_t      m_snd;

	// Bookkeeping
	logic [31:0] lcg_state;
	string       cur_test;
	bit          check_en;
	int          cycle_count = 0;
	int          check_count;
	int          err_count;
	int          test_count;
	int          test_errs;
	int          test_start;

	dkjr_rom_share i_dkjr_rom_share (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.slot_sync    (slot_sync),
		.cpu_addr     (cpu_addr),
		.vid_addr     (vid_addr),
		.obj_addr     (obj_addr),
		.wav_addr     (wav_addr),
		.dig_snd      (dig_snd),
		.rom_data     (rom_data),
		.rom_addr     (rom_addr),
		.prog_data    (prog_data),
		.vid1_data    (vid1_data),
		.vid2_data    (vid2_data),
		.obj1_data    (obj1_data),
		.obj2_data    (obj2_data),
		.obj3_data    (obj3_data),
		.obj4_data    (obj4_data),
		.wav_data     (wav_data),
		.snd_out      (snd_out)
	);

	// ------------------------------------------------------------
	// Models
	// ------------------------------------------------------------

	// ROM contents, low byte mixed with the bank bits
	function automatic dkjr_pkg::rom_byte_t rom_model(input dkjr_pkg::rom_addr_t a);
		return a[7:0] ^ a[18:11];
	endfunction

	// Combinational ROM read of the held address
	assign rom_data = rom_model(rom_addr);

	// CPU bank to ROM file bank
	function automatic dkjr_pkg::rom_addr_t remap_model(input dkjr_pkg::cpu_addr_t a);
		logic [4:0] file_bank;
		file_bank = a[15:11];
		if (a[15:11] == 5'h02) file_bank = 5'h06;
		if (a[15:11] == 5'h06) file_bank = 5'h02;
		if (a[15:11] == 5'h03) file_bank = 5'h0B;
		if (a[15:11] == 5'h0B) file_bank = 5'h07;
		if (a[15:11] == 5'h07) file_bank = 5'h03;
		if (a[15:11] == 5'h05) file_bank = 5'h09;
		if (a[15:11] == 5'h09) file_bank = 5'h05;
		return {3'b000, file_bank, a[10:0]};
	endfunction

	// Bias removal with both clips
	function automatic dkjr_pkg::snd_t mix_model(input dkjr_pkg::rom_byte_t w,
		input dkjr_pkg::snd_t d);
		int sum;
		int diff;
		sum = int'(w) + int'(d);
		diff = sum - int'(`DKJR_MIX_BIAS);
		if (sum >= int'(`DKJR_MIX_POS_LIM)) return 8'hFF;
		if (sum <= int'(`DKJR_MIX_NEG_LIM)) return 8'h00;
		return diff[7:0];
	endfunction

	// Fixed seed LCG
	function logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// One clock of the whole schedule, old values on the right
	always @(posedge W_CLK_12288M or negedge I_RESETn) begin : model_step
		dkjr_pkg::rom_byte_t rd;
		logic                rise;
		if (!I_RESETn) begin
			m_sync  = 2'b00;
			m_phase = '0;
			m_addr  = '0;
			m_prog  = '0;
			m_wav   = '0;
			m_vid1  = '0;
			m_vid2  = '0;
			m_obj1  = '0;
			m_obj2  = '0;
			m_obj3  = '0;
			m_obj4  = '0;
			m_snd   = '0;
		end else begin
			rd   = rom_model(m_addr);
			rise = m_sync[0] & ~m_sync[1];
			// Mixer sees the wave byte from before this edge
			m_snd = mix_model(m_wav, dig_snd);
			// Byte capture per slot
			case (m_phase)
				4'd0, 4'd3, 4'd6, 4'd9, 4'd12: m_prog = rd;
				4'd1:  m_wav  = rd;
				4'd4:  m_vid1 = rd;
				4'd5:  m_vid2 = rd;
				4'd10: m_obj1 = rd;
				4'd11: m_obj2 = rd;
				4'd13: m_obj3 = rd;
				4'd14: m_obj4 = rd;
				default: ;
			endcase
			// Next bus owner per slot
			case (m_phase)
				4'd0: m_addr = {`DKJR_WAV_BANK, wav_addr};
				4'd2, 4'd5, 4'd8, 4'd11, 4'd15: m_addr = remap_model(cpu_addr);
				4'd3:  m_addr = {3'b000, `DKJR_VID1_BANK, vid_addr};
				4'd4:  m_addr = {3'b000, `DKJR_VID2_BANK, vid_addr};
				4'd9:  m_addr = {3'b000, `DKJR_OBJ1_BANK, obj_addr};
				4'd10: m_addr = {3'b000, `DKJR_OBJ2_BANK, obj_addr};
				4'd12: m_addr = {3'b000, `DKJR_OBJ3_BANK, obj_addr};
				4'd13: m_addr = {3'b000, `DKJR_OBJ4_BANK, obj_addr};
				default: ;
			endcase
			if (rise || m_phase == dkjr_pkg::phase_t'(`DKJR_SLOTS - 1))
				m_phase = '0;
			else
				m_phase = m_phase + 4'd1;
			m_sync = {m_sync[0], slot_sync};
		end
	end

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------

	task automatic check_addr(input string sig, input dkjr_pkg::rom_addr_t exp,
		input dkjr_pkg::rom_addr_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s: %s expected %h actual %h", cur_test, sig, exp, act);
		end
	endtask

	task automatic check_byte(input string sig, input dkjr_pkg::rom_byte_t exp,
		input dkjr_pkg::rom_byte_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s: %s expected %h actual %h", cur_test, sig, exp, act);
		end
	endtask

	task automatic check_snd(input string sig, input dkjr_pkg::snd_t exp,
		input dkjr_pkg::snd_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s: %s expected %h actual %h", cur_test, sig, exp, act);
		end
	endtask

	// Mid cycle, well clear of both edges
	always @(negedge W_CLK_12288M) begin
		if (check_en) begin
			check_addr("rom_addr", m_addr, rom_addr);
			check_byte("prog_data", m_prog, prog_data);
			check_byte("wav_data", m_wav, wav_data);
			check_byte("vid1_data", m_vid1, vid1_data);
			check_byte("vid2_data", m_vid2, vid2_data);
			check_byte("obj1_data", m_obj1, obj1_data);
			check_byte("obj2_data", m_obj2, obj2_data);
			check_byte("obj3_data", m_obj3, obj3_data);
			check_byte("obj4_data", m_obj4, obj4_data);
			check_snd("snd_out", m_snd, snd_out);
		end
	end

	// ------------------------------------------------------------
	// Clock and timeout
	// ------------------------------------------------------------

	initial begin
		W_CLK_12288M = 1'b0;
		forever #(clk_half) W_CLK_12288M = ~W_CLK_12288M;
	end

	always @(posedge W_CLK_12288M) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------

	// Inputs move 1 ns after the edge
	task automatic next_cycle();
		@(posedge W_CLK_12288M);
		#1;
	endtask

	task automatic begin_test(input string name);
		cur_test   = name;
		test_errs  = err_count;
		test_start = cycle_count;
	endtask

	task automatic end_test();
		test_count++;
		$display("test %-10s %0d cycles, %0d errors", cur_test,
			cycle_count - test_start, err_count - test_errs);
	endtask

	// One sync pulse, new client addresses, then len - 1 quiet cycles
	task automatic play_round(input int len, input bit fixed_bank, input logic [4:0] bank,
		input bit fixed_mix, input logic [8:0] mix_sum);
		logic [15:0] r;
		logic [7:0]  w;
		logic [8:0]  d;
		next_cycle();
		slot_sync = 1'b1;
		cpu_addr  = lcg_next();
		if (fixed_bank) cpu_addr[15:11] = bank;
		r = lcg_next();
		vid_addr = r[11:0];
		r = lcg_next();
		obj_addr = r[11:0];
		wav_addr = lcg_next();
		r = lcg_next();
		dig_snd = r[7:0];
		if (fixed_mix) begin
			// Wave byte near half the sum, digital sound the rest
			w = mix_sum[8:1];
			d = mix_sum - {1'b0, w};
			wav_addr[7:0] = w ^ {`DKJR_WAV_BANK, wav_addr[15:11]};
			dig_snd = d[7:0];
		end
		repeat (len - 1) begin
			next_cycle();
			slot_sync = 1'b0;
			if (!fixed_mix) begin
				r = lcg_next();
				dig_snd = r[7:0];
			end
		end
	endtask

	initial begin
		logic [15:0] r;
		logic [8:0]  target;
		int          len;
		lcg_state   = 32'd45081;
		check_en    = 1'b0;
		check_count = 0;
		err_count   = 0;
		test_count  = 0;
		I_RESETn    = 1'b1;
		slot_sync   = 1'b0;
		cpu_addr    = '0;
		vid_addr    = '0;
		obj_addr    = '0;
		wav_addr    = '0;
		dig_snd     = '0;

		// Async reset alone, no clock edge yet
		begin_test("reset");
		#1;
		I_RESETn = 1'b0;
		#4;
		check_addr("rom_addr", '0, rom_addr);
		check_byte("prog_data", '0, prog_data);
		check_byte("wav_data", '0, wav_data);
		check_byte("vid1_data", '0, vid1_data);
		check_byte("vid2_data", '0, vid2_data);
		check_byte("obj1_data", '0, obj1_data);
		check_byte("obj2_data", '0, obj2_data);
		check_byte("obj3_data", '0, obj3_data);
		check_byte("obj4_data", '0, obj4_data);
		check_snd("snd_out", '0, snd_out);
		end_test();
		repeat (2) next_cycle();
		I_RESETn = 1'b1;
		check_en = 1'b1;

		// Full rounds, swapped banks first
		begin_test("schedule");
		for (int i = 0; i < sched_rounds; i++) begin
			if (i < 7)
				play_round(`DKJR_SLOTS, 1'b1, remap_banks[i], 1'b0, 9'h000);
			else
				play_round(`DKJR_SLOTS, 1'b0, 5'h00, 1'b0, 9'h000);
		end
		end_test();

		// Sums aimed at the limits, then random sums
		begin_test("mixer");
		for (int i = 0; i < mix_rounds; i++) begin
			if (i < 8) begin
				target = mix_edges[i];
			end else begin
				r = lcg_next();
				target = r[8:0];
				if (target == 9'h1FF) target = 9'h1FE;
			end
			play_round(`DKJR_SLOTS, 1'b0, 5'h00, 1'b1, target);
		end
		end_test();

		// Sync pulses at random spacing, mostly mid round
		begin_test("resync");
		for (int i = 0; i < resync_rounds; i++) begin
			r = lcg_next();
			len = 3 + (int'(r) % (resync_max_len - 2));
			play_round(len, 1'b0, 5'h00, 1'b0, 9'h000);
		end
		repeat (4) next_cycle();
		end_test();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+rtl
rtl/dkjr_pkg.sv
rtl/rom_phase_gen.sv
rtl/prog_bank_remap.sv
rtl/rom_slot_sequencer.sv
rtl/snd_mix_limit.sv
rtl/dkjr_rom_share.sv
verif/tb_dkjr_rom_share.sv

/* Makefile */
# Verilator build for the shared ROM scheduler and its testbench

TOP := tb_dkjr_rom_share

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
